// ==== verilog/pvt_pkg.sv ====
`default_nettype none

package pvt_pkg;

    // ----------------------------------------
    // Bus widths
    // ----------------------------------------
    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;

    // ----------------------------------------
    // Slot map
    // ----------------------------------------
    // Slot index sits in address bits 7:4, register index in bits 3:2
    localparam int SLOT_W    = 4;
    localparam int SLOT_LSB  = 4;
    localparam int NUM_SLOTS = 8;
    localparam int REG_W     = 2;
    localparam int REG_LSB   = 2;

    // Register offsets inside one slot
    localparam logic [REG_W-1:0] REG_CTRL   = 2'd0;
    localparam logic [REG_W-1:0] REG_STATUS = 2'd1;
    localparam logic [REG_W-1:0] REG_DATA   = 2'd2;
    localparam logic [REG_W-1:0] REG_TRIM   = 2'd3;

    // Conversion length in HCLK cycles
    localparam int CONV_CYCLES = 16;

    // AHB to APB bridge states
    typedef enum logic [2:0] {
        IDLE,
        SETUP,
        ACCESS,
        RDATA_HOLD,
        ERR1,
        ERR2
    } apb_state_t;

endpackage

`default_nettype wire

// ==== verilog/pvt_apb_if.sv ====
`default_nettype none

interface pvt_apb_if;
    import pvt_pkg::*;

    // Request
    logic [ADDR_W-1:0] paddr;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [DATA_W-1:0] pwdata;

    // Response, valid in the access cycle
    logic [DATA_W-1:0] prdata;
    logic              pslverr;

    modport bridge (
        output paddr, psel, penable, pwrite, pwdata,
        input  prdata, pslverr
    );

    modport mux (
        input  paddr, psel, penable, pwrite, pwdata,
        output prdata, pslverr
    );

    modport sensor (
        input  paddr, psel, penable, pwrite, pwdata,
        output prdata, pslverr
    );

endinterface

`default_nettype wire

// ==== verilog/pvt_endian_swap.sv ====
`default_nettype none

module pvt_endian_swap #(
    parameter int BIG_ENDIAN = 0
) (
    input  wire                        i_hclk,
    input  wire                        i_hresetn,
    input  wire                        i_hsel,
    input  wire  [1:0]                 i_htrans,
    input  wire                        i_hready,
    input  wire  [2:0]                 i_hsize,
    input  wire  [pvt_pkg::DATA_W-1:0] i_hwdata,
    input  wire  [pvt_pkg::DATA_W-1:0] i_hrdata_le,
    output logic [pvt_pkg::DATA_W-1:0] o_hwdata_le,
    output logic [pvt_pkg::DATA_W-1:0] o_hrdata
);
    import pvt_pkg::*;

    // Bit 1 swaps halfwords, bit 0 swaps bytes inside each halfword
    logic [1:0] swap_ctrl;
    logic [1:0] swap_ctrl_nxt;
    logic       swap_ctrl_en;

    function automatic logic [DATA_W-1:0] swap_word(input logic [DATA_W-1:0] w,
                                                     input logic [1:0]        ctrl);
        logic [DATA_W-1:0] t;
        t = ctrl[0] ? {w[23:16], w[31:24], w[7:0], w[15:8]} : w;
        return ctrl[1] ? {t[15:0], t[31:16]} : t;
    endfunction

    assign swap_ctrl_en     = i_hsel & i_htrans[1] & i_hready;
    assign swap_ctrl_nxt[1] = (BIG_ENDIAN != 0) && (i_hsize[1:0] == 2'b10);
    assign swap_ctrl_nxt[0] = (BIG_ENDIAN != 0) && (i_hsize[1:0] != 2'b00);

    // Held for the data phase of the accepted transfer
    always_ff @(posedge i_hclk or negedge i_hresetn) begin
        if (!i_hresetn) begin
            swap_ctrl <= 2'b00;
        end else if (swap_ctrl_en) begin
            swap_ctrl <= swap_ctrl_nxt;
        end
    end

    assign o_hwdata_le = swap_word(i_hwdata, swap_ctrl);
    assign o_hrdata    = swap_word(i_hrdata_le, swap_ctrl);

endmodule

`default_nettype wire

// ==== verilog/pvt_ahb_to_apb.sv ====
`default_nettype none

module pvt_ahb_to_apb (
    input  wire                        i_hclk,
    input  wire                        i_hresetn,
    input  wire                        i_hsel,
    input  wire  [pvt_pkg::ADDR_W-1:0] i_haddr,
    input  wire  [1:0]                 i_htrans,
    input  wire                        i_hwrite,
    input  wire                        i_hready,
    input  wire  [pvt_pkg::DATA_W-1:0] i_hwdata,
    output logic                       o_hreadyout,
    output logic [pvt_pkg::DATA_W-1:0] o_hrdata,
    output logic                       o_hresp,
    pvt_apb_if.bridge                  apb
);
    import pvt_pkg::*;

    apb_state_t        state;
    apb_state_t        state_nxt;
    logic              accept;
    logic [ADDR_W-1:0] addr_q;
    logic              write_q;
    logic [DATA_W-1:0] rdata_q;

    assign accept = i_hsel & i_htrans[1] & i_hready;

    // ----------------------------------------
    // State machine
    // ----------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:       state_nxt = accept ? SETUP : IDLE;
            SETUP:      state_nxt = ACCESS;
            ACCESS: begin
                if (apb.pslverr) begin
                    state_nxt = ERR1;
                end else if (write_q) begin
                    state_nxt = IDLE;
                end else begin
                    state_nxt = RDATA_HOLD;
                end
            end
            RDATA_HOLD: state_nxt = IDLE;
            ERR1:       state_nxt = ERR2;
            // Master may start the next transfer in the last error cycle
            ERR2:       state_nxt = accept ? SETUP : IDLE;
            default:    state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge i_hclk or negedge i_hresetn) begin
        if (!i_hresetn) begin
            state   <= IDLE;
            write_q <= 1'b0;
        end else begin
            state <= state_nxt;
            if (accept) begin
                write_q <= i_hwrite;
            end
        end
    end

    // Address phase capture
    always_ff @(posedge i_hclk) begin
        if (accept) begin
            addr_q <= i_haddr;
        end
    end

    // Read data taken in the access cycle
    always_ff @(posedge i_hclk) begin
        if (state == ACCESS) begin
            rdata_q <= apb.prdata;
        end
    end

    // ----------------------------------------
    // Outputs
    // ----------------------------------------
    assign o_hreadyout = !(state inside {SETUP, ACCESS, RDATA_HOLD, ERR1});
    assign o_hresp     = (state == ERR1) || (state == ERR2);
    assign o_hrdata    = rdata_q;

    assign apb.paddr   = addr_q;
    assign apb.psel    = (state == SETUP) || (state == ACCESS);
    assign apb.penable = (state == ACCESS);
    assign apb.pwrite  = write_q;
    // Master holds write data stable while the bridge stalls it
    assign apb.pwdata  = i_hwdata;

endmodule

`default_nettype wire

// ==== verilog/pvt_apb_slave_mux.sv ====
`default_nettype none

module pvt_apb_slave_mux (
    pvt_apb_if.mux    m,
    pvt_apb_if.bridge s [pvt_pkg::NUM_SLOTS]
);
    import pvt_pkg::*;

    localparam int SLOT_IDX_W = $clog2(NUM_SLOTS);

    logic [SLOT_W-1:0]    slot;
    logic [DATA_W-1:0]    slot_rdata [NUM_SLOTS];
    logic [NUM_SLOTS-1:0] slot_err;

    assign slot = m.paddr[SLOT_LSB +: SLOT_W];

    // ----------------------------------------
    // Request fan-out
    // ----------------------------------------
    for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_slot
        assign s[i].paddr   = m.paddr;
        assign s[i].psel    = m.psel && (slot == SLOT_W'(i));
        assign s[i].penable = m.penable;
        assign s[i].pwrite  = m.pwrite;
        assign s[i].pwdata  = m.pwdata;

        assign slot_rdata[i] = s[i].prdata;
        assign slot_err[i]   = s[i].pslverr;
    end

    // Response return, unwired slots answer with an error
    always_comb begin
        if (int'(slot) < NUM_SLOTS) begin
            m.prdata  = slot_rdata[slot[SLOT_IDX_W-1:0]];
            m.pslverr = slot_err[slot[SLOT_IDX_W-1:0]];
        end else begin
            m.prdata  = '0;
            m.pslverr = 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/pvt_sensor.sv ====
`default_nettype none

module pvt_sensor #(
    parameter int SENSOR_ID = 0
) (
    input  wire        i_hclk,
    input  wire        i_hresetn,
    pvt_apb_if.sensor  apb,
    output logic       o_irq
);
    import pvt_pkg::*;

    localparam int CNT_W = $clog2(CONV_CYCLES + 1);

    logic [REG_W-1:0]  reg_idx;
    logic              wr_en;
    logic              start;
    logic              ready_clr;
    logic              conv_done;
    logic [CNT_W-1:0]  count;
    logic              busy;
    logic              ready;
    logic              irq_en;
    logic [DATA_W-1:0] trim;
    logic [DATA_W-1:0] data;

    assign reg_idx   = apb.paddr[REG_LSB +: REG_W];
    assign wr_en     = apb.psel & apb.penable & apb.pwrite;
    assign start     = wr_en && (reg_idx == REG_CTRL) && apb.pwdata[0];
    assign ready_clr = wr_en && (reg_idx == REG_STATUS) && apb.pwdata[0];
    assign conv_done = (count == CNT_W'(1));
    assign busy      = (count != '0);

    // ----------------------------------------
    // Control registers and conversion
    // ----------------------------------------
    always_ff @(posedge i_hclk or negedge i_hresetn) begin
        if (!i_hresetn) begin
            irq_en <= 1'b0;
            trim   <= '0;
            count  <= '0;
            ready  <= 1'b0;
        end else begin
            if (wr_en && (reg_idx == REG_CTRL)) begin
                irq_en <= apb.pwdata[1];
            end
            if (wr_en && (reg_idx == REG_TRIM)) begin
                trim <= apb.pwdata;
            end
            // A new start restarts the count and drops a stale ready
            if (start) begin
                count <= CNT_W'(CONV_CYCLES);
            end else if (busy) begin
                count <= count - CNT_W'(1);
            end
            if (conv_done && !start) begin
                ready <= 1'b1;
            end else if (ready_clr || start) begin
                ready <= 1'b0;
            end
        end
    end

    // Result of the model: trim offset by the slot number
    always_ff @(posedge i_hclk) begin
        if (conv_done && !start) begin
            data <= trim + DATA_W'(SENSOR_ID);
        end
    end

    // ----------------------------------------
    // Read path
    // ----------------------------------------
    always_comb begin
        case (reg_idx)
            REG_CTRL:   apb.prdata = {{(DATA_W-2){1'b0}}, irq_en, 1'b0};
            REG_STATUS: apb.prdata = {{(DATA_W-2){1'b0}}, busy, ready};
            REG_DATA:   apb.prdata = data;
            default:    apb.prdata = trim;
        endcase
    end

    // DATA is read only
    assign apb.pslverr = apb.psel && apb.pwrite && (reg_idx == REG_DATA);

    assign o_irq = ready & irq_en;

endmodule

`default_nettype wire

// ==== verilog/pvt_sensor_ss.sv ====
`default_nettype none

module pvt_sensor_ss #(
    parameter int                          BIG_ENDIAN = 0,
    parameter logic [pvt_pkg::NUM_SLOTS-1:0] SENSOR_EN  = 8'h7F
) (
    input  wire                           i_hclk,
    input  wire                           i_hresetn,
    input  wire                           i_hsel,
    input  wire  [pvt_pkg::ADDR_W-1:0]    i_haddr,
    input  wire  [1:0]                    i_htrans,
    input  wire                           i_hwrite,
    input  wire  [2:0]                    i_hsize,
    input  wire                           i_hready,
    input  wire  [pvt_pkg::DATA_W-1:0]    i_hwdata,
    output wire                           o_hreadyout,
    output wire  [pvt_pkg::DATA_W-1:0]    o_hrdata,
    output wire                           o_hresp,
    output wire  [pvt_pkg::NUM_SLOTS-1:0] o_irq
);
    import pvt_pkg::*;

    // Little-endian data between the swap stage and the bridge
    wire [DATA_W-1:0] hwdata_le;
    wire [DATA_W-1:0] hrdata_le;

    pvt_apb_if u_apb_m ();
    pvt_apb_if u_apb_s [NUM_SLOTS] ();

    // ----------------------------------------
    // AHB side
    // ----------------------------------------
    pvt_endian_swap #(
        .BIG_ENDIAN (BIG_ENDIAN)
    ) u_endian_swap (
        .i_hclk      (i_hclk),
        .i_hresetn   (i_hresetn),
        .i_hsel      (i_hsel),
        .i_htrans    (i_htrans),
        .i_hready    (i_hready),
        .i_hsize     (i_hsize),
        .i_hwdata    (i_hwdata),
        .i_hrdata_le (hrdata_le),
        .o_hwdata_le (hwdata_le),
        .o_hrdata    (o_hrdata)
    );

    pvt_ahb_to_apb u_ahb_to_apb (
        .i_hclk      (i_hclk),
        .i_hresetn   (i_hresetn),
        .i_hsel      (i_hsel),
        .i_haddr     (i_haddr),
        .i_htrans    (i_htrans),
        .i_hwrite    (i_hwrite),
        .i_hready    (i_hready),
        .i_hwdata    (hwdata_le),
        .o_hreadyout (o_hreadyout),
        .o_hrdata    (hrdata_le),
        .o_hresp     (o_hresp),
        .apb         (u_apb_m)
    );

    pvt_apb_slave_mux u_apb_slave_mux (
        .m (u_apb_m),
        .s (u_apb_s)
    );

    // ----------------------------------------
    // Sensor slots
    // ----------------------------------------
    for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_slot
        if (SENSOR_EN[i]) begin : g_sensor
            pvt_sensor #(
                .SENSOR_ID (i)
            ) u_sensor (
                .i_hclk    (i_hclk),
                .i_hresetn (i_hresetn),
                .apb       (u_apb_s[i]),
                .o_irq     (o_irq[i])
            );
        end else begin : g_no_sensor
            // Empty slot always answers with an error
            assign u_apb_s[i].prdata  = '0;
            assign u_apb_s[i].pslverr = 1'b1;
            assign o_irq[i]           = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== bench/pvt_clk_gen.sv ====
`default_nettype none

module pvt_clk_gen (
    output logic o_hclk,
    output logic o_hresetn
);

    // Period of 10 time units
    initial begin
        o_hclk = 1'b0;
        forever #5 o_hclk = ~o_hclk;
    end

    // Reset held over the first two rising edges
    initial begin
        o_hresetn = 1'b0;
        repeat (2) @(posedge o_hclk);
        #1;
        o_hresetn = 1'b1;
    end

endmodule

`default_nettype wire

// ==== bench/pvt_sensor_ss_tb.sv ====
`default_nettype none

module pvt_sensor_ss_tb;
    import pvt_pkg::*;

    localparam logic [NUM_SLOTS-1:0] SENSOR_EN_CFG = 8'h7F;
    localparam logic [31:0] SEED = 32'hb974_1a6a;
    localparam logic [2:0]  SIZE_BYTE = 3'b000;
    localparam logic [2:0]  SIZE_HALF = 3'b001;
    localparam logic [2:0]  SIZE_WORD = 3'b010;
    localparam int MAX_POLLS = 8;
    // About 100 transfers of 5 cycles each, with a wide margin
    localparam int TIMEOUT_CYCLES = 4000;

    typedef struct {
        logic [3:0]           slot;
        logic [1:0]           reg_idx;
        logic                 write;
        logic [2:0]           size;
        logic [31:0]          rdata;
        logic [31:0]          exp_rdata;
        logic                 chk_data;
        logic                 resp_wait;
        logic                 resp_done;
        logic                 exp_err;
        int                   waits;
        logic [NUM_SLOTS-1:0] irq;
        logic [NUM_SLOTS-1:0] exp_irq;
        logic                 chk_irq;
    } xfer_t;

    logic                 hclk;
    logic                 hresetn;
    logic                 hsel;
    logic [ADDR_W-1:0]    haddr;
    logic [1:0]           htrans;
    logic                 hwrite;
    logic [2:0]           hsize;
    logic                 hready;
    logic [DATA_W-1:0]    hwdata;
    wire                  hreadyout;
    wire  [DATA_W-1:0]    hrdata;
    wire                  hresp;
    wire  [NUM_SLOTS-1:0] irq;

    // Reference model state, indexed by the full 4-bit slot
    logic [31:0] trim_model [16];
    logic [15:0] ie_model;
    logic [15:0] ready_model;

    xfer_t xfer_q [$];
    event  xfer_posted;
    int    n_posted = 0;
    int    n_compared = 0;
    int    n_errors = 0;
    int    cycle_cnt = 0;

    pvt_clk_gen u_clk_gen (
        .o_hclk    (hclk),
        .o_hresetn (hresetn)
    );

    pvt_sensor_ss #(
        .BIG_ENDIAN (1),
        .SENSOR_EN  (SENSOR_EN_CFG)
    ) u_dut (
        .i_hclk      (hclk),
        .i_hresetn   (hresetn),
        .i_hsel      (hsel),
        .i_haddr     (haddr),
        .i_htrans    (htrans),
        .i_hwrite    (hwrite),
        .i_hsize     (hsize),
        .i_hready    (hready),
        .i_hwdata    (hwdata),
        .o_hreadyout (hreadyout),
        .o_hrdata    (hrdata),
        .o_hresp     (hresp),
        .o_irq       (irq)
    );

    // ----------------------------------------
    // Reference functions
    // ----------------------------------------
    // Big-endian lane order for each transfer size
    function automatic logic [31:0] be_swap(input logic [31:0] w, input logic [2:0] size);
        logic [31:0] r;
        case (size)
            SIZE_WORD: r = {w[7:0], w[15:8], w[23:16], w[31:24]};
            SIZE_HALF: r = {w[23:16], w[31:24], w[7:0], w[15:8]};
            default:   r = w;
        endcase
        return r;
    endfunction

    function automatic logic slot_enabled(input logic [3:0] slot);
        return (slot < 4'd8) && SENSOR_EN_CFG[slot[2:0]];
    endfunction

    function automatic logic expected_err(input logic [3:0] slot, input logic [1:0] reg_idx,
                                          input logic write);
        return !slot_enabled(slot) || (write && (reg_idx == REG_DATA));
    endfunction

    function automatic logic [31:0] expected_rdata(input logic [3:0] slot,
                                                   input logic [1:0] reg_idx,
                                                   input logic [2:0] size);
        logic [31:0] le;
        case (reg_idx)
            REG_CTRL: le = {30'h0, ie_model[slot], 1'b0};
            REG_DATA: le = trim_model[slot] + {28'h0, slot};
            default:  le = trim_model[slot];
        endcase
        return be_swap(le, size);
    endfunction

    function automatic logic [NUM_SLOTS-1:0] expected_irq();
        logic [15:0] active;
        active = ready_model & ie_model;
        return active[NUM_SLOTS-1:0];
    endfunction

    // ----------------------------------------
    // AHB transfers
    // ----------------------------------------
    // Called 1 time unit after a rising edge while the bus is idle
    task automatic ahb_transfer(input logic [3:0] slot, input logic [1:0] reg_idx,
                                input logic write, input logic [2:0] size,
                                input logic [31:0] wdata, output xfer_t rec);
        rec.slot      = slot;
        rec.reg_idx   = reg_idx;
        rec.write     = write;
        rec.size      = size;
        rec.exp_err   = expected_err(slot, reg_idx, write);
        rec.exp_rdata = 32'h0;
        rec.chk_data  = 1'b0;
        rec.chk_irq   = 1'b1;
        rec.waits     = 0;
        rec.resp_wait = 1'b0;
        hsel   = 1'b1;
        haddr  = {8'h00, slot, reg_idx, 2'b00};
        htrans = 2'b10;
        hwrite = write;
        hsize  = size;
        @(posedge hclk);
        #1;
        hsel   = 1'b0;
        htrans = 2'b00;
        hwdata = wdata;
        @(negedge hclk);
        while (!hreadyout) begin
            rec.waits     = rec.waits + 1;
            rec.resp_wait = hresp;
            @(negedge hclk);
        end
        rec.resp_done = hresp;
        rec.rdata     = hrdata;
        rec.irq       = irq;
        @(posedge hclk);
        #1;
    endtask

    task automatic post_result(input xfer_t rec);
        xfer_q.push_back(rec);
        n_posted = n_posted + 1;
        -> xfer_posted;
    endtask

    task automatic write_reg(input logic [3:0] slot, input logic [1:0] reg_idx,
                             input logic [31:0] value);
        xfer_t rec;
        ahb_transfer(slot, reg_idx, 1'b1, SIZE_WORD, be_swap(value, SIZE_WORD), rec);
        if (!rec.exp_err) begin
            case (reg_idx)
                REG_TRIM: trim_model[slot] = value;
                REG_CTRL: begin
                    ie_model[slot] = value[1];
                    if (value[0]) begin
                        ready_model[slot] = 1'b0;
                    end
                end
                REG_STATUS: begin
                    if (value[0]) begin
                        ready_model[slot] = 1'b0;
                    end
                end
                default: ;
            endcase
        end
        rec.exp_irq = expected_irq();
        post_result(rec);
    endtask

    task automatic read_reg(input logic [3:0] slot, input logic [1:0] reg_idx,
                            input logic [2:0] size);
        xfer_t rec;
        ahb_transfer(slot, reg_idx, 1'b0, size, 32'h0, rec);
        rec.chk_data  = !rec.exp_err;
        rec.exp_rdata = expected_rdata(slot, reg_idx, size);
        rec.exp_irq   = expected_irq();
        post_result(rec);
    endtask

    task automatic poll_ready(input logic [3:0] slot);
        xfer_t       rec;
        logic [31:0] status;
        logic        seen;
        int          n;
        seen = 1'b0;
        n    = 0;
        while (!seen && (n < MAX_POLLS)) begin
            ahb_transfer(slot, REG_STATUS, 1'b0, SIZE_WORD, 32'h0, rec);
            status = be_swap(rec.rdata, SIZE_WORD);
            seen   = status[0];
            if (seen) begin
                ready_model[slot] = 1'b1;
            end else begin
                // Ready may rise after the APB read but before the transfer ends
                rec.chk_irq = 1'b0;
            end
            rec.exp_irq = expected_irq();
            post_result(rec);
            n = n + 1;
        end
        assert (seen) else begin
            n_errors = n_errors + 1;
            $display("Slot %0d never reported ready after %0d polls", slot, MAX_POLLS);
        end
    endtask

    // ----------------------------------------
    // Comparison
    // ----------------------------------------
    initial begin : compare
        xfer_t rec;
        int    exp_waits;
        forever begin
            @(xfer_posted);
            while (xfer_q.size() != 0) begin
                rec = xfer_q.pop_front();
                // Error takes SETUP, ACCESS and ERR1, a read adds RDATA_HOLD
                exp_waits = (rec.exp_err || !rec.write) ? 3 : 2;
                assert ((rec.resp_wait == rec.exp_err) && (rec.resp_done == rec.exp_err)) else begin
                    n_errors = n_errors + 1;
                    $display("FAIL o_hresp slot %0d reg %0d: got %h/%h, expected %h",
                             rec.slot, rec.reg_idx, rec.resp_wait, rec.resp_done, rec.exp_err);
                end
                assert (rec.waits == exp_waits) else begin
                    n_errors = n_errors + 1;
                    $display("FAIL o_hreadyout low cycles slot %0d reg %0d: got %h, expected %h",
                             rec.slot, rec.reg_idx, rec.waits, exp_waits);
                end
                if (rec.chk_data) begin
                    assert (rec.rdata == rec.exp_rdata) else begin
                        n_errors = n_errors + 1;
                        $display("FAIL o_hrdata slot %0d reg %0d size %0d: got %h, expected %h",
                                 rec.slot, rec.reg_idx, rec.size, rec.rdata, rec.exp_rdata);
                    end
                end
                if (rec.chk_irq) begin
                    assert (rec.irq == rec.exp_irq) else begin
                        n_errors = n_errors + 1;
                        $display("FAIL o_irq after slot %0d reg %0d: got %h, expected %h",
                                 rec.slot, rec.reg_idx, rec.irq, rec.exp_irq);
                    end
                end
                n_compared = n_compared + 1;
            end
        end
    end

    always @(posedge hclk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial begin : stimulus
        logic [31:0] seed_ret;
        logic [31:0] w;
        logic [3:0]  slot;
        hsel        = 1'b0;
        haddr       = '0;
        htrans      = 2'b00;
        hwrite      = 1'b0;
        hsize       = SIZE_WORD;
        // Only slave on the bus
        hready      = 1'b1;
        hwdata      = '0;
        ie_model    = '0;
        ready_model = '0;
        for (int i = 0; i < 16; i++) begin
            trim_model[i] = 32'h0;
        end
        seed_ret = $urandom(SEED);
        wait (hresetn);
        @(posedge hclk);
        #1;
        assert (hreadyout && !hresp && (irq == '0)) else begin
            n_errors = n_errors + 1;
            $display("Outputs not in their reset state after reset");
        end

        // Trim round trip
        for (int s = 0; s < NUM_SLOTS; s++) begin
            slot = 4'(s);
            if (slot_enabled(slot)) begin
                w = $urandom;
                write_reg(slot, REG_TRIM, be_swap(w, SIZE_WORD));
                read_reg(slot, REG_TRIM, SIZE_WORD);
            end
        end

        // Conversion with interrupt
        for (int s = 0; s < NUM_SLOTS; s++) begin
            slot = 4'(s);
            if (slot_enabled(slot)) begin
                write_reg(slot, REG_CTRL, 32'h3);
                read_reg(slot, REG_CTRL, SIZE_WORD);
                poll_ready(slot);
                read_reg(slot, REG_DATA, SIZE_WORD);
                write_reg(slot, REG_STATUS, 32'h1);
            end
        end

        // Conversion without interrupt enable keeps o_irq low
        write_reg(4'd0, REG_CTRL, 32'h1);
        poll_ready(4'd0);
        write_reg(4'd0, REG_STATUS, 32'h1);

        // Error responses
        write_reg(4'd7, REG_TRIM, 32'h1234_5678);
        read_reg(4'd7, REG_TRIM, SIZE_WORD);
        for (int s = 8; s < 16; s++) begin
            read_reg(4'(s), REG_CTRL, SIZE_WORD);
        end
        write_reg(4'd0, REG_DATA, 32'hdead_beef);
        write_reg(4'd3, REG_DATA, 32'h0000_0001);

        // Narrow reads of TRIM
        for (int s = 0; s < NUM_SLOTS; s++) begin
            slot = 4'(s);
            if (slot_enabled(slot)) begin
                read_reg(slot, REG_TRIM, SIZE_HALF);
                read_reg(slot, REG_TRIM, SIZE_BYTE);
            end
        end

        repeat (4) @(posedge hclk);
        assert (n_compared == n_posted) else begin
            n_errors = n_errors + 1;
            $display("Only %0d of %0d transfers were compared", n_compared, n_posted);
        end
        $display("Transfers checked: %0d, errors: %0d", n_compared, n_errors);
        if (n_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== pvt_sensor_ss.f ====
verilog/pvt_pkg.sv
verilog/pvt_apb_if.sv
verilog/pvt_endian_swap.sv
verilog/pvt_ahb_to_apb.sv
verilog/pvt_apb_slave_mux.sv
verilog/pvt_sensor.sv
verilog/pvt_sensor_ss.sv
bench/pvt_clk_gen.sv
bench/pvt_sensor_ss_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the PVT sensor subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
    --top-module pvt_sensor_ss_tb \
    -Mdir obj_dir \
    -f pvt_sensor_ss.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator compile failed with status $status"
    exit 1
fi

./obj_dir/Vpvt_sensor_ss_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST RESULT: PASS" "$LOG"; then
    exit 0
fi
exit 1
